/* sim.f */
rtl/muldiv_pkg.sv
rtl/muldiv_operand_stage.sv
rtl/muldiv_iter_engine.sv
rtl/muldiv_result_stage.sv
rtl/muldiv_unit.sv
+incdir+test
test/muldiv_tb.sv

/* test/muldiv_ref_model.svh */
//----------------------------------------------------------------------
// reference model for the multiply/divide testbench
// expected result function and expected-result queue helpers
//----------------------------------------------------------------------

`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

// expected 64-bit result from function code and operands
// multiply gives {high, low}, divide gives {remainder, quotient}
function automatic muldiv_pkg::dword_t expected_result(input muldiv_pkg::fn_t   fn,
                                                       input muldiv_pkg::word_t a,
                                                       input muldiv_pkg::word_t b);
  longint            sa;
  longint            sb;
  longint unsigned   ua;
  longint unsigned   ub;
  muldiv_pkg::word_t quo;
  muldiv_pkg::word_t rem;
  // 64-bit signed and unsigned views of the operands
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  ua = {32'd0, a};
  ub = {32'd0, b};
  if (fn == muldiv_pkg::FN_MUL) begin
    return muldiv_pkg::dword_t'(sa * sb);
  end
  if (fn == muldiv_pkg::FN_MULU) begin
    return muldiv_pkg::dword_t'(ua * ub);
  end
  if (b == '0) begin
    // divide by zero gives an all-ones quotient and a as remainder
    quo = 32'hffff_ffff;
    rem = a;
  end else if (fn == muldiv_pkg::FN_DIV) begin
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // signed overflow wraps back to the most negative value
      quo = 32'h8000_0000;
      rem = '0;
    end else begin
      // integer division truncates toward zero and the remainder follows a
      quo = muldiv_pkg::word_t'(sa / sb);
      rem = muldiv_pkg::word_t'(sa % sb);
    end
  end else begin
    quo = muldiv_pkg::word_t'(ua / ub);
    rem = muldiv_pkg::word_t'(ua % ub);
  end
  return {rem, quo};
endfunction

// record the expected result of a request that just transferred
function automatic void push_expected(input muldiv_pkg::fn_t   fn,
                                      input muldiv_pkg::word_t a,
                                      input muldiv_pkg::word_t b);
  exp_q.push_back(expected_result(fn, a, b));
endfunction

// oldest outstanding expected result
function automatic muldiv_pkg::dword_t pop_expected();
  return exp_q.pop_front();
endfunction

`endif

/* test/muldiv_tb.sv */
//----------------------------------------------------------------------
// testbench for the multiply/divide unit
// clock, reset, seeded random stimulus and back-pressure
// result checks against a model and a run timeout
//----------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module muldiv_tb;

  // operations per test
  localparam int NUM_UDIV  = 40;
  localparam int NUM_SDIV  = 40;
  localparam int NUM_DIVZ  = 16;
  localparam int NUM_MUL   = 40;
  localparam int NUM_BP    = 60;
  localparam int TOTAL_OPS = NUM_UDIV + NUM_SDIV + NUM_DIVZ + NUM_MUL + NUM_BP;

  // 35 cycles per operation, four times over for back-pressure, plus margin
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 35 * 4 + 200;

  // stimulus classes
  localparam int KIND_UDIV  = 0;
  localparam int KIND_SDIV  = 1;
  localparam int KIND_DIVZ  = 2;
  localparam int KIND_MUL   = 3;
  localparam int KIND_MIXED = 4;

  logic               clk;
  logic               reset;
  logic               req_val;
  logic               req_rdy;
  muldiv_pkg::fn_t    req_fn;
  muldiv_pkg::word_t  req_a;
  muldiv_pkg::word_t  req_b;
  logic               resp_val;
  logic               resp_rdy;
  muldiv_pkg::dword_t resp_result;

  // expected results in request order
  muldiv_pkg::dword_t exp_q[$];

  int   req_count   = 0;
  int   resp_count  = 0;
  int   error_count = 0;
  int   cycle_count = 0;
  int   test_count  = 0;
  logic backpressure;

  `include "muldiv_ref_model.svh"

  muldiv_unit u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: responses missing");
      $display("Done: errors found");
      $finish;
    end
  end

  //--------------------------------------------------------------------
  // monitor sampled on the rising edge
  //--------------------------------------------------------------------

  always @(posedge clk) begin
    muldiv_pkg::dword_t expected;
    if (!reset && req_val && req_rdy) begin
      push_expected(req_fn, req_a, req_b);
      req_count++;
    end
    if (!reset && resp_val && resp_rdy) begin
      assert (exp_q.size() > 0) else begin
        $display("unexpected response at %0t with no request outstanding", $time);
        error_count++;
      end
      if (exp_q.size() > 0) begin
        expected = pop_expected();
        assert (resp_result === expected) else begin
          $display("error at %0t: response %h, expected %h", $time, resp_result, expected);
          error_count++;
        end
      end
      resp_count++;
    end
  end

  //--------------------------------------------------------------------
  // stimulus driven on the falling edge
  //--------------------------------------------------------------------

  // advance to the next falling edge and redraw resp_rdy
  task automatic next_cycle();
    @(negedge clk);
    if (backpressure) begin
      // ready about one cycle in 32, so a held response often outlasts
      // the engine latency and the stall reaches back to the request port
      resp_rdy = ($urandom_range(0, 31) == 0);
    end else begin
      resp_rdy = 1'b1;
    end
  endtask

  // random operand weighted toward extreme values
  function automatic muldiv_pkg::word_t pick_operand();
    int sel;
    sel = $urandom_range(0, 7);
    case (sel)
      0: return 32'h0000_0000;
      1: return 32'h0000_0001;
      2: return 32'hffff_ffff;
      3: return 32'h8000_0000;
      4: return 32'h7fff_ffff;
      5: return muldiv_pkg::word_t'($urandom_range(0, 255));
      default: return $urandom;
    endcase
  endfunction

  // hold one request until it transfers
  task automatic issue_request(input muldiv_pkg::fn_t   fn,
                               input muldiv_pkg::word_t a,
                               input muldiv_pkg::word_t b);
    int start_count;
    start_count = req_count;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    next_cycle();
    while (req_count == start_count) begin
      next_cycle();
    end
  endtask

  // idle checks right after reset
  task automatic check_reset_state();
    int start_errors;
    start_errors = error_count;
    repeat (3) begin
      assert (req_rdy === 1'b1 && resp_val === 1'b0) else begin
        $display("error at %0t: after reset req_rdy %b, resp_val %b",
                 $time, req_rdy, resp_val);
        error_count++;
      end
      next_cycle();
    end
    test_count++;
    $display("test reset state: %0d errors", error_count - start_errors);
  endtask

  // one batch of requests, then drain every response
  task automatic run_batch(input string name, input int kind, input int count,
                           input logic bp);
    int                start_errors;
    muldiv_pkg::fn_t   fn;
    muldiv_pkg::word_t a;
    muldiv_pkg::word_t b;
    start_errors = error_count;
    backpressure = bp;
    for (int i = 0; i < count; i++) begin
      a = pick_operand();
      b = pick_operand();
      case (kind)
        KIND_UDIV: fn = muldiv_pkg::FN_DIVU;
        KIND_SDIV: fn = muldiv_pkg::FN_DIV;
        KIND_DIVZ: begin
          fn = ($urandom_range(0, 1) == 1) ? muldiv_pkg::FN_DIV : muldiv_pkg::FN_DIVU;
          b  = '0;
        end
        KIND_MUL: fn = ($urandom_range(0, 1) == 1) ? muldiv_pkg::FN_MUL : muldiv_pkg::FN_MULU;
        default: fn = muldiv_pkg::fn_t'($urandom_range(0, 3));
      endcase
      // ordinary divide tests keep a nonzero divisor
      if ((kind == KIND_UDIV || kind == KIND_SDIV) && b == '0) begin
        b = 32'd3;
      end
      // signed divide opens with the overflow case
      if (kind == KIND_SDIV && i == 0) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      issue_request(fn, a, b);
      // occasional gap unless requests run back to back
      if (!bp && $urandom_range(0, 3) == 0) begin
        req_val = 1'b0;
        next_cycle();
      end
    end
    req_val = 1'b0;
    while (resp_count != req_count) begin
      next_cycle();
    end
    test_count++;
    $display("test %s: %0d operations, %0d errors", name, count,
             error_count - start_errors);
  endtask

  //--------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------

  initial begin
    void'($urandom(32'hd3b3));
    reset        = 1'b1;
    req_val      = 1'b0;
    req_fn       = muldiv_pkg::FN_MUL;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b1;
    backpressure = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_reset_state();
    run_batch("unsigned divide", KIND_UDIV, NUM_UDIV, 1'b0);
    run_batch("signed divide", KIND_SDIV, NUM_SDIV, 1'b0);
    run_batch("divide by zero", KIND_DIVZ, NUM_DIVZ, 1'b0);
    run_batch("multiply", KIND_MUL, NUM_MUL, 1'b0);
    run_batch("back-pressure", KIND_MIXED, NUM_BP, 1'b1);

    // every expected result was matched by a response
    assert (exp_q.size() == 0) else begin
      $display("expected-result queue not empty, %0d responses never arrived", exp_q.size());
      error_count++;
    end

    $display("tests %0d, operations %0d, responses %0d, errors %0d",
             test_count, req_count, resp_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/muldiv_unit.sv */
//--------------------------------------------------------------------
// multiply/divide unit top level
// operand stage, iterative engine and result stage in a val/rdy chain
//--------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module muldiv_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  muldiv_pkg::fn_t    req_fn,
  input  muldiv_pkg::word_t  req_a,
  input  muldiv_pkg::word_t  req_b,
  output logic               resp_val,
  input  logic               resp_rdy,
  output muldiv_pkg::dword_t resp_result
);

  // operand stage to engine
  logic              op_val;
  logic              op_rdy;
  logic              op_is_div;
  muldiv_pkg::word_t op_mag_a;
  muldiv_pkg::word_t op_mag_b;
  logic              op_neg_lo;
  logic              op_neg_hi;

  // engine to result stage
  logic               raw_val;
  logic               raw_rdy;
  logic               raw_is_div;
  muldiv_pkg::dword_t raw_result;
  logic               raw_neg_lo;
  logic               raw_neg_hi;

  // magnitudes and sign decisions
  muldiv_operand_stage u_operand (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .req_fn    (req_fn),
    .req_a     (req_a),
    .req_b     (req_b),
    .op_val    (op_val),
    .op_rdy    (op_rdy),
    .op_is_div (op_is_div),
    .op_mag_a  (op_mag_a),
    .op_mag_b  (op_mag_b),
    .op_neg_lo (op_neg_lo),
    .op_neg_hi (op_neg_hi)
  );

  // shared iterative multiply/divide
  muldiv_iter_engine u_engine (
    .clk        (clk),
    .reset      (reset),
    .op_val     (op_val),
    .op_rdy     (op_rdy),
    .op_is_div  (op_is_div),
    .op_mag_a   (op_mag_a),
    .op_mag_b   (op_mag_b),
    .op_neg_lo  (op_neg_lo),
    .op_neg_hi  (op_neg_hi),
    .raw_val    (raw_val),
    .raw_rdy    (raw_rdy),
    .raw_is_div (raw_is_div),
    .raw_result (raw_result),
    .raw_neg_lo (raw_neg_lo),
    .raw_neg_hi (raw_neg_hi)
  );

  // sign correction and response register
  muldiv_result_stage u_result (
    .clk         (clk),
    .reset       (reset),
    .raw_val     (raw_val),
    .raw_rdy     (raw_rdy),
    .raw_is_div  (raw_is_div),
    .raw_result  (raw_result),
    .raw_neg_lo  (raw_neg_lo),
    .raw_neg_hi  (raw_neg_hi),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

/* rtl/muldiv_result_stage.sv */
//--------------------------------------------------------------------
// result stage: sign correction of the raw engine result
// and the response register
//--------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module muldiv_result_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               raw_val,
  output logic               raw_rdy,
  input  logic               raw_is_div,
  input  muldiv_pkg::dword_t raw_result,
  input  logic               raw_neg_lo,
  input  logic               raw_neg_hi,
  output logic               resp_val,
  input  logic               resp_rdy,
  output muldiv_pkg::dword_t resp_result
);

  // divide halves
  muldiv_pkg::word_t quo;
  muldiv_pkg::word_t rem;
  muldiv_pkg::word_t quo_fix;
  muldiv_pkg::word_t rem_fix;

  // corrected results
  muldiv_pkg::dword_t div_fix;
  muldiv_pkg::dword_t mul_fix;

  logic raw_fire;

  assign quo = raw_result[31:0];
  assign rem = raw_result[63:32];

  // quotient and remainder each follow their own flag
  assign quo_fix = raw_neg_lo ? (~quo + 32'd1) : quo;
  assign rem_fix = raw_neg_hi ? (~rem + 32'd1) : rem;
  assign div_fix = {rem_fix, quo_fix};

  // product negates as one 64-bit value
  assign mul_fix = raw_neg_lo ? (~raw_result + 64'd1) : raw_result;

  // take a new item when empty or when the held one leaves
  assign raw_rdy  = !resp_val || resp_rdy;
  assign raw_fire = raw_val && raw_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (raw_fire) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (raw_fire) begin
      resp_result <= raw_is_div ? div_fix : mul_fix;
    end
  end

  // response is held steady under back-pressure
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

`default_nettype wire

/* rtl/muldiv_iter_engine.sv */
//--------------------------------------------------------------------
// iterative engine: control FSM and 65-bit shift register
// shift-add multiply or restoring divide, one bit per cycle
//--------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module muldiv_iter_engine (
  input  logic               clk,
  input  logic               reset,
  input  logic               op_val,
  output logic               op_rdy,
  input  logic               op_is_div,
  input  muldiv_pkg::word_t  op_mag_a,
  input  muldiv_pkg::word_t  op_mag_b,
  input  logic               op_neg_lo,
  input  logic               op_neg_hi,
  output logic               raw_val,
  input  logic               raw_rdy,
  output logic               raw_is_div,
  output muldiv_pkg::dword_t raw_result,
  output logic               raw_neg_lo,
  output logic               raw_neg_hi
);

  //------------------------------------------------------------------
  // state
  //------------------------------------------------------------------

  muldiv_pkg::eng_state_t state_q;
  muldiv_pkg::count_t     count_q;

  // set on accept, first calc cycle arms the counter
  logic arm_q;

  // working register and held divisor or multiplicand
  muldiv_pkg::acc_t  acc_q;
  muldiv_pkg::word_t b_q;

  // flags that travel with the operation
  logic is_div_q;
  logic neg_lo_q;
  logic neg_hi_q;

  logic op_fire;
  logic raw_fire;
  logic iterate;

  // divide step
  muldiv_pkg::acc_t div_shift;
  logic [32:0]      div_diff;
  muldiv_pkg::acc_t div_next;

  // multiply step
  logic [32:0]      mul_sum;
  muldiv_pkg::acc_t mul_next;

  //------------------------------------------------------------------
  // handshakes
  //------------------------------------------------------------------

  assign op_rdy   = (state_q == muldiv_pkg::ENG_IDLE);
  assign raw_val  = (state_q == muldiv_pkg::ENG_DONE);
  assign op_fire  = op_val && op_rdy;
  assign raw_fire = raw_val && raw_rdy;
  assign iterate  = (state_q == muldiv_pkg::ENG_CALC) && !arm_q;

  //------------------------------------------------------------------
  // datapath steps
  //------------------------------------------------------------------

  // restoring divide
  // shift in the next dividend bit, try subtracting the divisor
  // diff bit 32 set means the trial went negative, keep the old value
  assign div_shift = acc_q << 1;
  assign div_diff  = div_shift[64:32] - {1'b0, b_q};
  assign div_next  = div_diff[32] ? {div_shift[64:1], 1'b0}
                                  : {div_diff, div_shift[31:1], 1'b1};

  // shift-add multiply
  // add multiplicand into the high half when the low bit is set, then shift right
  assign mul_sum  = {1'b0, acc_q[63:32]} + (acc_q[0] ? {1'b0, b_q} : 33'd0);
  assign mul_next = {1'b0, mul_sum, acc_q[31:1]};

  //------------------------------------------------------------------
  // control FSM
  //------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= muldiv_pkg::ENG_IDLE;
      count_q <= '0;
      arm_q   <= 1'b0;
    end else begin
      case (state_q)
        muldiv_pkg::ENG_IDLE: begin
          if (op_fire) begin
            state_q <= muldiv_pkg::ENG_CALC;
            arm_q   <= 1'b1;
          end
        end
        muldiv_pkg::ENG_CALC: begin
          if (arm_q) begin
            // load cycle
            count_q <= muldiv_pkg::count_t'(muldiv_pkg::ITER_COUNT - 1);
            arm_q   <= 1'b0;
          end else if (count_q == '0) begin
            // last iteration
            state_q <= muldiv_pkg::ENG_DONE;
          end else begin
            count_q <= count_q - 5'd1;
          end
        end
        muldiv_pkg::ENG_DONE: begin
          if (raw_fire) begin
            state_q <= muldiv_pkg::ENG_IDLE;
          end
        end
        default: begin
          state_q <= muldiv_pkg::ENG_IDLE;
        end
      endcase
    end
  end

  // working registers
  always_ff @(posedge clk) begin
    if (op_fire) begin
      acc_q    <= {33'd0, op_mag_a};
      b_q      <= op_mag_b;
      is_div_q <= op_is_div;
      neg_lo_q <= op_neg_lo;
      neg_hi_q <= op_neg_hi;
    end else if (iterate) begin
      acc_q <= is_div_q ? div_next : mul_next;
    end
  end

  assign raw_result = acc_q[63:0];
  assign raw_is_div = is_div_q;
  assign raw_neg_lo = neg_lo_q;
  assign raw_neg_hi = neg_hi_q;

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------

  // one load cycle plus ITER_COUNT iterations, result only seen in done
  a_eng_latency: assert property (@(posedge clk) disable iff (reset)
    op_fire |=> !raw_val [*(muldiv_pkg::ITER_COUNT + 1)]
                ##1 (raw_val && state_q == muldiv_pkg::ENG_DONE));

  // counter moves only while calculating
  a_eng_count: assert property (@(posedge clk) disable iff (reset)
    !$stable(count_q) |-> ($past(state_q) == muldiv_pkg::ENG_CALC));

endmodule

`default_nettype wire

/* rtl/muldiv_operand_stage.sv */
//--------------------------------------------------------------------
// operand stage: request register with operand magnitudes,
// result sign decisions and divide-by-zero handling
//--------------------------------------------------------------------

`timescale 1ns/10ps
`default_nettype none

module muldiv_operand_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  muldiv_pkg::fn_t   req_fn,
  input  muldiv_pkg::word_t req_a,
  input  muldiv_pkg::word_t req_b,
  output logic              op_val,
  input  logic              op_rdy,
  output logic              op_is_div,
  output muldiv_pkg::word_t op_mag_a,
  output muldiv_pkg::word_t op_mag_b,
  output logic              op_neg_lo,
  output logic              op_neg_hi
);

  // function decode
  logic is_signed;
  logic is_div;

  // operand signs, only meaningful for signed functions
  logic a_neg;
  logic b_neg;
  logic b_zero;
  logic prod_neg;

  muldiv_pkg::word_t mag_a;
  muldiv_pkg::word_t mag_b;

  logic req_fire;

  assign is_signed = (req_fn == muldiv_pkg::FN_MUL) || (req_fn == muldiv_pkg::FN_DIV);
  assign is_div    = (req_fn == muldiv_pkg::FN_DIV) || (req_fn == muldiv_pkg::FN_DIVU);

  assign a_neg  = is_signed && req_a[31];
  assign b_neg  = is_signed && req_b[31];
  assign b_zero = (req_b == '0);

  // sign of the product, or of the quotient
  assign prod_neg = a_neg ^ b_neg;

  // two's complement magnitudes
  assign mag_a = a_neg ? (~req_a + 32'd1) : req_a;
  assign mag_b = b_neg ? (~req_b + 32'd1) : req_b;

  // accept when empty, or when the held item leaves this cycle
  assign req_rdy  = !op_val || op_rdy;
  assign req_fire = req_val && req_rdy;

  // valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      op_val <= 1'b0;
    end else if (req_fire) begin
      op_val <= 1'b1;
    end else if (op_rdy) begin
      op_val <= 1'b0;
    end
  end

  // payload
  // quotient keeps all ones on divide by zero, so no negate there
  // remainder always takes the sign of a
  always_ff @(posedge clk) begin
    if (req_fire) begin
      op_is_div <= is_div;
      op_mag_a  <= mag_a;
      op_mag_b  <= mag_b;
      op_neg_lo <= is_div ? (prod_neg && !b_zero) : prod_neg;
      op_neg_hi <= is_div ? a_neg : prod_neg;
    end
  end

  // held item stays put until the engine takes it
  a_op_hold: assert property (@(posedge clk) disable iff (reset)
    (op_val && !op_rdy) |=> (op_val && $stable(op_mag_a) && $stable(op_mag_b)
                              && $stable(op_is_div)));

endmodule

`default_nettype wire

/* rtl/muldiv_pkg.sv */
//--------------------------------------------------------------------
// shared types and constants for the iterative multiply/divide unit
// word and result widths, function codes, iteration count, engine FSM
//--------------------------------------------------------------------

`default_nettype none

package muldiv_pkg;

  //------------------------------------------------------------------
  // data widths
  //------------------------------------------------------------------

  // one 32-bit operand, or one half of a result
  typedef logic [31:0] word_t;

  // full result
  // multiply gives {high, low}, divide gives {remainder, quotient}
  typedef logic [63:0] dword_t;

  // engine working register
  // top bit is headroom for the shifted partial remainder
  // and for the carry out of the multiply add
  typedef logic [64:0] acc_t;

  //------------------------------------------------------------------
  // function codes
  //------------------------------------------------------------------

  // bit 1 set selects divide, bit 0 clear selects signed
  typedef logic [1:0] fn_t;

  localparam fn_t FN_MUL  = 2'd0;
  localparam fn_t FN_MULU = 2'd1;
  localparam fn_t FN_DIV  = 2'd2;
  localparam fn_t FN_DIVU = 2'd3;

  //------------------------------------------------------------------
  // iteration control
  //------------------------------------------------------------------

  // one result bit per iteration
  localparam int ITER_COUNT = 32;

  // counts down from ITER_COUNT-1 to zero
  typedef logic [4:0] count_t;

  // engine control FSM
  // idle accepts and loads, calc iterates, done holds the raw result
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_CALC,
    ENG_DONE
  } eng_state_t;

endpackage

`default_nettype wire
